// ==== cla_adder_wb.f ====
+incdir+logic
logic/cla_pkg.sv
logic/cla_group.sv
logic/group_carry_unit.sv
logic/adder_regs.sv
logic/cla_adder_wb.sv
tb/tb_cla_adder_wb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail message.

set -e

cd "$(dirname "$0")"

TOP=tb_cla_adder_wb
LOG=sim.log

verilator --binary --timing \
    --top-module "$TOP" \
    -f cla_adder_wb.f \
    -o "$TOP"

./obj_dir/"$TOP" > "$LOG" 2>&1
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== tb/tb_cla_adder_wb.sv ====
`timescale 1ns/10ps

`include "cla_settings.svh"

module tb_cla_adder_wb;
    import cla_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int ACK_LIMIT       = 16;
    localparam int DONE_POLLS      = 20;
    localparam int FIXED_ROWS      = 14;
    localparam int RANDOM_ROWS     = 32;
    localparam int ROW_COUNT       = FIXED_ROWS + RANDOM_ROWS;
    localparam int WATCHDOG_CYCLES = ROW_COUNT * 200 + 1000;

    // each row is {a, b, sub}.
    localparam logic [64:0] FIXED_TABLE [FIXED_ROWS] = '{
        {32'hFFFF_FFFF, 32'h0000_0001, 1'b0},  // carry runs through every group.
        {32'h0000_00FF, 32'h0000_0001, 1'b0},
        {32'h00FF_FFFF, 32'h0000_0001, 1'b0},
        {32'h0000_0000, 32'h0000_0001, 1'b1},  // borrow, so no carry.
        {32'h1234_5678, 32'h1234_5678, 1'b1},
        {32'h8000_0000, 32'h8000_0000, 1'b0},
        {32'h0000_FFFF, 32'h0000_0001, 1'b0},
        {32'h7FFF_FFFF, 32'h0000_0001, 1'b0},
        {32'h0000_0005, 32'h0000_0003, 1'b1},
        {32'h0000_0003, 32'h0000_0005, 1'b1},
        {32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0},
        {32'h0000_0000, 32'h0000_0000, 1'b0},
        {32'h0000_0000, 32'h0000_0000, 1'b1},
        {32'hFF00_FF00, 32'h00FF_0100, 1'b0}   // carry made in group 1 and passed up.
    };

    logic     clk;
    logic     reset;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_adr_t  adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    logic     ack;

    operand_t row_a      [ROW_COUNT];
    operand_t row_b      [ROW_COUNT];
    logic     row_sub    [ROW_COUNT];
    operand_t row_result [ROW_COUNT];
    wb_data_t row_status [ROW_COUNT];

    int check_count    = 0;
    int mismatch_count = 0;
    int stall_count    = 0;

    cla_adder_wb u_cla_adder_wb (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // fills one table row and works out its result and status words.
    task automatic set_row(input int idx, input operand_t a, input operand_t b, input logic sub);
        logic [32:0] full;
        full = {1'b0, a} + {1'b0, (sub ? ~b : b)} + {32'd0, sub};
        row_a[idx]      = a;
        row_b[idx]      = b;
        row_sub[idx]    = sub;
        row_result[idx] = full[31:0];
        row_status[idx] = {29'd0, (full[31:0] == 32'd0), full[32], 1'b1};
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (got !== expected) begin
            mismatch_count++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, what, got, expected);
        end
    endtask

    ////////////////////////////////
    // wishbone bus cycles
    ////////////////////////////////
    // called a little after a rising edge, and returns at the same point of a later cycle.
    task automatic bus_cycle(input logic write, input wb_adr_t addr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = write;
        adr    = addr;
        dat_w  = wdata;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!ack && waited < ACK_LIMIT);
        if (ack) begin
            rdata = dat_r;
        end else begin
            stall_count++;
            $display("bus stall: no ack within %0d cycles at address %0d", ACK_LIMIT, addr);
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input wb_adr_t addr, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input wb_adr_t addr, output wb_data_t data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    task automatic wait_done(input int row, output wb_data_t status);
        int polls;
        polls = 0;
        do begin
            wb_read(wb_adr_t'(`REG_STATUS), status);
            polls++;
        end while (!status[0] && polls < DONE_POLLS);
        if (!status[0]) begin
            stall_count++;
            $display("row %0d never showed done after %0d status reads", row, DONE_POLLS);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] seed;
        operand_t    ra;
        operand_t    rb;
        wb_data_t    rd;

        clk   = 1'b0;
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;

        for (int i = 0; i < FIXED_ROWS; i++) begin
            set_row(i, FIXED_TABLE[i][64:33], FIXED_TABLE[i][32:1], FIXED_TABLE[i][0]);
        end
        seed = 32'h5c92_35ec;
        for (int i = FIXED_ROWS; i < ROW_COUNT; i++) begin
            seed = next_random(seed);
            ra   = seed;
            seed = next_random(seed);
            rb   = seed;
            seed = next_random(seed);
            set_row(i, ra, rb, seed[0]);  // add and subtract mixed.
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        ////////////////////////////////
        // register state after reset
        ////////////////////////////////
        wb_read(wb_adr_t'(`REG_RESULT), rd);
        check_value(rd, 32'd0, "result after reset");
        wb_read(wb_adr_t'(`REG_STATUS), rd);
        check_value(rd, 32'd0, "status after reset");
        wb_read(wb_adr_t'(`REG_CTRL), rd);
        check_value(rd, 32'd0, "ctrl after reset");
        for (int k = 5; k < 8; k++) begin
            wb_read(wb_adr_t'(k), rd);
            check_value(rd, 32'd0, $sformatf("unmapped address %0d", k));
        end
        wb_write(wb_adr_t'(`REG_OPA), 32'hA5C3_0F96);
        wb_write(wb_adr_t'(`REG_OPB), 32'h5A3C_F069);
        wb_read(wb_adr_t'(`REG_OPA), rd);
        check_value(rd, 32'hA5C3_0F96, "opa readback");
        wb_read(wb_adr_t'(`REG_OPB), rd);
        check_value(rd, 32'h5A3C_F069, "opb readback");
        wb_write(wb_adr_t'(`REG_RESULT), 32'hDEAD_BEEF);  // read-only, so it is dropped.
        wb_write(wb_adr_t'(`REG_STATUS), 32'h0000_0007);
        wb_read(wb_adr_t'(`REG_RESULT), rd);
        check_value(rd, 32'd0, "result after write to read-only word");
        wb_read(wb_adr_t'(`REG_STATUS), rd);
        check_value(rd, 32'd0, "status after write to read-only word");

        ////////////////////////////////
        // table of operations
        ////////////////////////////////
        for (int i = 0; i < ROW_COUNT; i++) begin
            wb_write(wb_adr_t'(`REG_OPA), row_a[i]);
            wb_write(wb_adr_t'(`REG_OPB), row_b[i]);
            wb_write(wb_adr_t'(`REG_CTRL), {31'd0, row_sub[i]});
            wait_done(i, rd);
            check_value(rd, row_status[i], $sformatf("row %0d status", i));
            wb_read(wb_adr_t'(`REG_RESULT), rd);
            check_value(rd, row_result[i], $sformatf("row %0d result", i));
            wb_read(wb_adr_t'(`REG_CTRL), rd);
            check_value(rd, {31'd0, row_sub[i]}, $sformatf("row %0d ctrl", i));
        end

        $display("checks: %0d, mismatches: %0d, bus or done stalls: %0d",
                 check_count, mismatch_count, stall_count);
        if (mismatch_count == 0 && stall_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/cla_adder_wb.sv ====
`timescale 1ns/10ps

`include "cla_settings.svh"

module cla_adder_wb (
    input  logic               clk,
    input  logic               reset,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  cla_pkg::wb_adr_t   adr,
    input  cla_pkg::wb_data_t  dat_w,
    output cla_pkg::wb_data_t  dat_r,
    output logic               ack
);
    import cla_pkg::*;

    logic        launch;
    operand_t    op_a;
    operand_t    op_b_eff;
    logic        cin;
    operand_t    sum0;
    operand_t    sum1;
    group_bits_t gen;
    group_bits_t prop;
    logic        grp_valid;
    operand_t    result;
    logic        carry;
    logic        zero;
    logic        result_valid;

    adder_regs u_adder_regs (
        .clk          (clk),
        .reset        (reset),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .dat_r        (dat_r),
        .ack          (ack),
        .launch       (launch),
        .op_a         (op_a),
        .op_b_eff     (op_b_eff),
        .cin          (cin),
        .result       (result),
        .carry        (carry),
        .zero         (zero),
        .result_valid (result_valid)
    );

    //////////////////////////////
    // group cells
    //////////////////////////////
    for (genvar i = 0; i < `CLA_GROUPS; i++) begin : u_group
        if (i == 0) begin : g_lead
            cla_group u_cla_group (
                .clk    (clk),
                .reset  (reset),
                .launch (launch),
                .a      (op_a[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH]),
                .b      (op_b_eff[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH]),
                .sum0   (sum0[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH]),
                .sum1   (sum1[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH]),
                .gen    (gen[i]),
                .prop   (prop[i]),
                .valid  (grp_valid)  // all cells run in lockstep.
            );
        end else begin : g_rest
            cla_group u_cla_group (
                .clk    (clk),
                .reset  (reset),
                .launch (launch),
                .a      (op_a[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH]),
                .b      (op_b_eff[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH]),
                .sum0   (sum0[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH]),
                .sum1   (sum1[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH]),
                .gen    (gen[i]),
                .prop   (prop[i]),
                .valid  ()
            );
        end
    end

    group_carry_unit u_group_carry_unit (
        .clk          (clk),
        .reset        (reset),
        .valid        (grp_valid),
        .cin          (cin),
        .sum0         (sum0),
        .sum1         (sum1),
        .gen          (gen),
        .prop         (prop),
        .result       (result),
        .carry        (carry),
        .zero         (zero),
        .result_valid (result_valid)
    );

endmodule

// ==== logic/adder_regs.sv ====
`timescale 1ns/10ps

`include "cla_settings.svh"

module adder_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  cla_pkg::wb_adr_t   adr,
    input  cla_pkg::wb_data_t  dat_w,
    output cla_pkg::wb_data_t  dat_r,
    output logic               ack,
    output logic               launch,
    output cla_pkg::operand_t  op_a,
    output cla_pkg::operand_t  op_b_eff,
    output logic               cin,
    input  cla_pkg::operand_t  result,
    input  logic               carry,
    input  logic               zero,
    input  logic               result_valid
);
    import cla_pkg::*;

    regs_state_t state;
    logic        req;
    logic        wr_ctrl;
    operand_t    op_b;
    logic        sub;
    operand_t    result_q;
    logic        carry_q;
    logic        zero_q;
    logic        done_q;
    wb_data_t    rd_data;

    //////////////////////////////
    // bus handshake
    //////////////////////////////
    assign req     = (state == st_idle) && cyc && stb;  // a new cycle is taken only while idle.
    assign ack     = (state == st_ack);
    assign wr_ctrl = req && we && (adr == wb_adr_t'(`REG_CTRL));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= req ? st_ack : st_idle;  // ack lasts one cycle.
        end
    end

    //////////////////////////////
    // operands and launch
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            op_a   <= '0;
            op_b   <= '0;
            sub    <= 1'b0;
            launch <= 1'b0;
        end else begin
            launch <= wr_ctrl;
            if (req && we) begin
                case (adr)
                    wb_adr_t'(`REG_OPA):  op_a <= dat_w;
                    wb_adr_t'(`REG_OPB):  op_b <= dat_w;
                    wb_adr_t'(`REG_CTRL): sub  <= dat_w[0];
                    default: ;  // read-only and unmapped words ignore writes.
                endcase
            end
        end
    end

    // a - b is a + ~b + 1, so the carry out reads as no borrow.
    assign op_b_eff = sub ? ~op_b : op_b;
    assign cin      = sub;

    //////////////////////////////
    // result and status
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            result_q <= '0;
            carry_q  <= 1'b0;
            zero_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            if (result_valid) begin
                result_q <= result;
                carry_q  <= carry;
                zero_q   <= zero;
                done_q   <= 1'b1;
            end
            if (wr_ctrl) begin
                done_q <= 1'b0;  // a fresh launch keeps done low until its own result.
            end
        end
    end

    always_comb begin
        case (adr)
            wb_adr_t'(`REG_OPA):    rd_data = op_a;
            wb_adr_t'(`REG_OPB):    rd_data = op_b;
            wb_adr_t'(`REG_CTRL):   rd_data = wb_data_t'(sub);
            wb_adr_t'(`REG_RESULT): rd_data = result_q;
            wb_adr_t'(`REG_STATUS): rd_data = wb_data_t'({zero_q, carry_q, done_q});
            default:                rd_data = '0;
        endcase
    end

    // read data is sampled with the request and held through ack.
    always_ff @(posedge clk) begin
        if (req) begin
            dat_r <= rd_data;
        end
    end

endmodule

// ==== logic/group_carry_unit.sv ====
`timescale 1ns/10ps

`include "cla_settings.svh"

module group_carry_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  logic                  cin,
    input  cla_pkg::operand_t     sum0,
    input  cla_pkg::operand_t     sum1,
    input  cla_pkg::group_bits_t  gen,
    input  cla_pkg::group_bits_t  prop,
    output cla_pkg::operand_t     result,
    output logic                  carry,
    output logic                  zero,
    output logic                  result_valid
);
    import cla_pkg::*;

    logic                 cin_q;
    logic [`CLA_GROUPS:0] g_ext;  // cin sits below the group generates.
    logic [`CLA_GROUPS:0] gc;     // gc[k] is the carry into group k.
    logic                 term;
    operand_t             sum_sel;

    // taken on the same edge that the groups register their sums.
    always_ff @(posedge clk) begin
        cin_q <= cin;
    end

    assign g_ext = {gen, cin_q};

    //////////////////////////////
    // group lookahead
    //////////////////////////////
    always_comb begin
        term = 1'b0;
        for (int k = 0; k <= `CLA_GROUPS; k++) begin
            gc[k] = 1'b0;
            for (int j = 0; j <= k; j++) begin
                term = g_ext[j];
                for (int m = j; m < k; m++) begin
                    term = term & prop[m];  // carry made at j, passed by every group up to k.
                end
                gc[k] = gc[k] | term;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `CLA_GROUPS; i++) begin
            sum_sel[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH] =
                gc[i] ? sum1[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH]
                      : sum0[i*`CLA_GROUP_WIDTH +: `CLA_GROUP_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            result <= sum_sel;
            carry  <= gc[`CLA_GROUPS];
            zero   <= ~|sum_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= valid;
        end
    end

endmodule

// ==== logic/cla_group.sv ====
`timescale 1ns/10ps

`include "cla_settings.svh"

module cla_group (
    input  logic             clk,
    input  logic             reset,
    input  logic             launch,
    input  cla_pkg::group_t  a,
    input  cla_pkg::group_t  b,
    output cla_pkg::group_t  sum0,
    output cla_pkg::group_t  sum1,
    output logic             gen,
    output logic             prop,
    output logic             valid
);
    import cla_pkg::*;

    group_t                      p;
    group_t                      g;
    logic [`CLA_GROUP_WIDTH:0]   c0;     // carries for a carry-in of 0.
    logic [`CLA_GROUP_WIDTH:0]   run_p;  // and of all p below each bit.
    logic [`CLA_GROUP_WIDTH-1:0] c1;     // carries for a carry-in of 1.

    assign p = a ^ b;
    assign g = a & b;

    always_comb begin
        c0[0]    = 1'b0;
        run_p[0] = 1'b1;
        for (int i = 0; i < `CLA_GROUP_WIDTH; i++) begin
            c0[i+1]    = g[i] | (p[i] & c0[i]);
            run_p[i+1] = run_p[i] & p[i];
        end
    end

    // a carry-in of 1 only gets to bit i through an unbroken run of propagates.
    assign c1 = c0[`CLA_GROUP_WIDTH-1:0] | run_p[`CLA_GROUP_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (launch) begin
            sum0 <= p ^ c0[`CLA_GROUP_WIDTH-1:0];
            sum1 <= p ^ c1;
            gen  <= c0[`CLA_GROUP_WIDTH];     // carry out with nothing coming in.
            prop <= run_p[`CLA_GROUP_WIDTH];  // the whole group passes a carry.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= launch;
        end
    end

endmodule

// ==== logic/cla_pkg.sv ====
package cla_pkg;

`include "cla_settings.svh"

    // a full operand, or a full result.
    typedef logic [`CLA_WIDTH-1:0] operand_t;

    // one slice handled by a single group cell.
    typedef logic [`CLA_GROUP_WIDTH-1:0] group_t;

    // one bit per group cell.
    typedef logic [`CLA_GROUPS-1:0] group_bits_t;

    typedef logic [`CLA_ADR_WIDTH-1:0] wb_adr_t;

    typedef logic [31:0] wb_data_t;

    // bus handshake states of the register block.
    typedef enum logic {
        st_idle,
        st_ack
    } regs_state_t;

endpackage

// ==== logic/cla_settings.svh ====
`ifndef CLA_SETTINGS_SVH
`define CLA_SETTINGS_SVH

// datapath geometry.
`define CLA_WIDTH        32
`define CLA_GROUP_WIDTH  8
`define CLA_GROUPS       (`CLA_WIDTH / `CLA_GROUP_WIDTH)

// wishbone word address width.
`define CLA_ADR_WIDTH    3

//////////////////////////////
// register word addresses
//////////////////////////////
`define REG_OPA          0
`define REG_OPB          1
`define REG_CTRL         2
`define REG_RESULT       3
`define REG_STATUS       4

`endif
